/* compile.f */
hdl/cache_geom_pkg.sv
hdl/dbus_pkg.sv
hdl/dtag_banks.sv
hdl/ddata_bank.sv
hdl/dcache_ctrl.sv
hdl/dcache.sv
test/mem_model.sv
test/dcache_tb.sv

/* hdl/cache_geom_pkg.sv */
package cache_geom_pkg;

    localparam int ADDR_W     = 32;
    localparam int WAYS       = 2;
    localparam int LINES      = 64;     // Lines per way
    localparam int LINE_WORDS = 4;
    localparam int WORD_IDX_W = $clog2(LINE_WORDS);
    localparam int LINE_IDX_W = $clog2(LINES);
    localparam int BYTE_OFS_W = 2;
    localparam int LINE_OFS_W = WORD_IDX_W + BYTE_OFS_W;
    localparam int TAG_W      = ADDR_W - LINE_IDX_W - LINE_OFS_W;

    typedef logic [$clog2(WAYS)-1:0] way_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [LINE_IDX_W-1:0]   line_idx_t;
    typedef logic [WORD_IDX_W-1:0]   word_idx_t;

    // Address split for lookup and word select
    typedef struct packed {
        tag_t                  tag;
        line_idx_t             line_idx;
        word_idx_t             word_idx;
        logic [BYTE_OFS_W-1:0] byte_ofs;
    } addr_fields_t;

    // Address split for line-aligned fills
    typedef struct packed {
        logic [ADDR_W-LINE_OFS_W-1:0] line_base;
        logic [LINE_OFS_W-1:0]        line_ofs;
    } addr_line_t;

    typedef union packed {
        addr_fields_t fields;
        addr_line_t   line;
    } dcache_addr_u;

endpackage

/* hdl/dbus_pkg.sv */
package dbus_pkg;

    localparam int WORD_W = 32;
    localparam int BE_W   = WORD_W / 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BE_W-1:0]   be_t;

    // Load/store unit request, valid with new_request
    typedef struct packed {
        word_t addr;
        logic  load;
        logic  store;
        be_t   be;
        word_t data;
    } ls_req_t;

    typedef struct packed {
        word_t      addr;
        logic       rnw;
        be_t        be;
        word_t      data;
        logic [1:0] size;   // Words minus one
    } mem_req_t;

    typedef struct packed {
        logic  data_valid;  // One strobe per returned word
        word_t data;
        logic  inv_valid;   // Held until inv_ack
        word_t inv_addr;
        logic  inv_ack;
    } mem_rsp_t;

endpackage

/* hdl/dcache.sv */
`timescale 1ns/10ps

module dcache
    import cache_geom_pkg::*;
    import dbus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cache_on,
    input  logic     new_request,
    input  ls_req_t  ls_req,
    output logic     ready,
    output logic     data_valid,
    output word_t    data_out,
    output logic     mem_request,
    input  logic     mem_ack,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,
    output logic     inv_ack
);

    dcache_addr_u lookup_addr;
    dcache_addr_u req_addr;     // Stage 2 address as sent to memory
    dcache_addr_u inv_addr;
    logic         hit;
    way_t         hit_way;
    logic         tag_update;
    way_t         update_way;
    logic         rd_en;
    way_t         rd_way;
    logic         wr_en;
    way_t         wr_way;
    word_idx_t    wr_word;
    be_t          wr_be;
    word_t        wr_data;
    word_t        bank_data;

    assign req_addr = mem_req.addr;
    assign inv_addr = mem_rsp.inv_addr;

    dtag_banks tag_banks0 (
        .clk, .rst,
        .lookup      (new_request),
        .lookup_addr,
        .update      (tag_update),
        .update_way,
        .update_addr (req_addr),
        .inv_valid   (mem_rsp.inv_valid),
        .inv_addr,
        .hit, .hit_way, .inv_ack
    );

    ddata_bank data_bank0 (
        .clk, .rd_en, .rd_way,
        .rd_addr (lookup_addr),
        .wr_en, .wr_way,
        .wr_line (req_addr.fields.line_idx),
        .wr_word, .wr_be, .wr_data,
        .rd_data (bank_data)
    );

    dcache_ctrl ctrl0 (.*);

endmodule

/* hdl/dcache_ctrl.sv */
`timescale 1ns/10ps

module dcache_ctrl
    import cache_geom_pkg::*;
    import dbus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         cache_on,
    input  logic         new_request,
    input  ls_req_t      ls_req,
    input  logic         hit,
    input  way_t         hit_way,
    input  word_t        bank_data,
    input  logic         mem_ack,
    input  mem_rsp_t     mem_rsp,
    output logic         ready,
    output logic         data_valid,
    output word_t        data_out,
    output dcache_addr_u lookup_addr,
    output logic         tag_update,
    output way_t         update_way,
    output logic         rd_en,
    output way_t         rd_way,
    output logic         wr_en,
    output way_t         wr_way,
    output word_idx_t    wr_word,
    output be_t          wr_be,
    output word_t        wr_data,
    output logic         mem_request,
    output mem_req_t     mem_req
);

    ls_req_t      stage2;
    dcache_addr_u stage2_addr;
    logic         second_cycle;
    logic         cached_load;      // Load that may hit or fill a line
    logic         load_hit;
    logic         store_hit;
    logic         miss_start;
    logic         store_done;
    logic         request_q;
    logic         idle;
    logic         fill_wr;
    logic         line_complete;
    logic         is_target_word;
    way_t         rr_way;
    way_t         fill_way;
    word_idx_t    word_count;
    word_t        miss_data;

    assign lookup_addr = ls_req.addr;

    always_ff @(posedge clk) begin
        if (new_request) begin
            stage2 <= ls_req;
        end
    end

    assign stage2_addr = stage2.addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            second_cycle <= 1'b0;
            cached_load  <= 1'b0;
        end else begin
            second_cycle <= new_request;
            if (new_request) begin
                cached_load <= ls_req.load & cache_on;
            end
        end
    end

    // Decision in the second cycle
    assign load_hit   = second_cycle & cached_load & hit;
    assign store_hit  = second_cycle & stage2.store & hit;
    assign miss_start = second_cycle & ~load_hit;   // Miss, uncached load or store
    assign store_done = mem_ack & stage2.store;

    // Round-robin replacement, moves on each tag update
    always_ff @(posedge clk) begin
        if (rst) begin
            tag_update <= 1'b0;
            rr_way     <= '0;
        end else begin
            tag_update <= second_cycle & cached_load & ~hit;
            if (tag_update) begin
                rr_way <= rr_way + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (second_cycle) begin
            fill_way <= rr_way;
        end
    end

    assign update_way = fill_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            request_q <= 1'b0;
        end else if (mem_ack) begin
            request_q <= 1'b0;
        end else if (miss_start) begin
            request_q <= 1'b1;
        end
    end

    assign mem_request = request_q | miss_start;

    always_comb begin
        mem_req.rnw  = stage2.load;
        mem_req.be   = stage2.be;
        mem_req.data = stage2.data;
        if (cached_load) begin
            mem_req.addr = {stage2_addr.line.line_base, {LINE_OFS_W{1'b0}}};
            mem_req.size = 2'(LINE_WORDS - 1);
        end else begin
            mem_req.addr = {stage2_addr.fields.tag, stage2_addr.fields.line_idx,
                            stage2_addr.fields.word_idx, {BYTE_OFS_W{1'b0}}};
            mem_req.size = 2'd0;    // Single word
        end
    end

    // Fill words arrive in order 0 to LINE_WORDS-1
    assign fill_wr        = mem_rsp.data_valid & cached_load;
    assign is_target_word = ~cached_load | (word_count == stage2_addr.fields.word_idx);
    assign line_complete  = mem_rsp.data_valid &
                            (~cached_load | (word_count == word_idx_t'(LINE_WORDS - 1)));

    always_ff @(posedge clk) begin
        if (rst) begin
            word_count <= '0;
        end else if (fill_wr) begin
            word_count <= word_count + 1'b1;
        end
    end

    // Bank write port shared by store hits and fills
    assign wr_en   = store_hit | fill_wr;
    assign wr_way  = store_hit ? hit_way : fill_way;
    assign wr_word = store_hit ? stage2_addr.fields.word_idx : word_count;
    assign wr_be   = store_hit ? stage2.be : '1;
    assign wr_data = store_hit ? stage2.data : mem_rsp.data;

    assign rd_en  = load_hit;
    assign rd_way = hit_way;

    always_ff @(posedge clk) begin
        if (rst | data_valid) begin
            miss_data <= '0;
        end else if (mem_rsp.data_valid & is_target_word) begin
            miss_data <= mem_rsp.data;
        end
    end

    assign data_out = miss_data | bank_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            idle       <= 1'b1;
            data_valid <= 1'b0;
        end else begin
            data_valid <= load_hit | line_complete;
            if (new_request) begin
                idle <= 1'b0;
            end else if (load_hit | line_complete | store_done) begin
                idle <= 1'b1;
            end
        end
    end

    assign ready = idle | load_hit | store_done;

endmodule

/* hdl/ddata_bank.sv */
`timescale 1ns/10ps

module ddata_bank
    import cache_geom_pkg::*;
    import dbus_pkg::*;
(
    input  logic         clk,
    input  logic         rd_en,
    input  way_t         rd_way,
    input  dcache_addr_u rd_addr,
    input  logic         wr_en,
    input  way_t         wr_way,
    input  line_idx_t    wr_line,
    input  word_idx_t    wr_word,
    input  be_t          wr_be,
    input  word_t        wr_data,
    output word_t        rd_data
);

    logic [BE_W-1:0][7:0] mem [WAYS][LINES*LINE_WORDS];
    word_t                way_word [WAYS];

    // Every way is read alongside the tag lookup
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            way_word[w] <= mem[w][{rd_addr.fields.line_idx, rd_addr.fields.word_idx}];
        end
    end

    // Store hits use their byte enables, fills write whole words
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BE_W; b++) begin
                if (wr_be[b]) begin
                    mem[wr_way][{wr_line, wr_word}][b] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // Zero unless a hit was read, so it can be ORed with miss data
    always_ff @(posedge clk) begin
        rd_data <= rd_en ? way_word[rd_way] : '0;
    end

endmodule

/* hdl/dtag_banks.sv */
`timescale 1ns/10ps

module dtag_banks
    import cache_geom_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         lookup,
    input  dcache_addr_u lookup_addr,
    input  logic         update,
    input  way_t         update_way,
    input  dcache_addr_u update_addr,
    input  logic         inv_valid,
    input  dcache_addr_u inv_addr,
    output logic         hit,
    output way_t         hit_way,
    output logic         inv_ack
);

    tag_t             tag_mem [WAYS][LINES];
    logic [LINES-1:0] valid [WAYS];
    tag_t             tag_rd [WAYS];    // Tags read at lookup
    dcache_addr_u     stage2_addr;
    logic [WAYS-1:0]  way_match;
    logic [WAYS-1:0]  inv_match;
    logic             inv_go;

    // First cycle: read every way in parallel
    always_ff @(posedge clk) begin
        if (lookup) begin
            stage2_addr <= lookup_addr;
            for (int w = 0; w < WAYS; w++) begin
                tag_rd[w] <= tag_mem[w][lookup_addr.fields.line_idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            tag_mem[update_way][update_addr.fields.line_idx] <= update_addr.fields.tag;
        end
    end

    // One invalidation per inv_valid, acked on the following cycle
    assign inv_go = inv_valid & ~inv_ack;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            inv_match[w] = (tag_mem[w][inv_addr.fields.line_idx] == inv_addr.fields.tag);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                valid[w] <= '0;
            end
            inv_ack <= 1'b0;
        end else begin
            if (update) begin
                valid[update_way][update_addr.fields.line_idx] <= 1'b1;
            end
            for (int w = 0; w < WAYS; w++) begin
                if (inv_go && inv_match[w]) begin
                    valid[w][inv_addr.fields.line_idx] <= 1'b0;   // Invalidation wins
                end
            end
            inv_ack <= inv_go;
        end
    end

    // Second cycle: compare against the registered tag
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            way_match[w] = valid[w][stage2_addr.fields.line_idx] &&
                           (tag_rd[w] == stage2_addr.fields.tag);
            if (way_match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |way_match;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the dcache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module dcache_tb -Mdir obj_dir -f compile.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vdcache_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

/* test/dcache_tb.sv */
`timescale 1ns/10ps

module dcache_tb
    import cache_geom_pkg::*;
    import dbus_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int N_TESTS     = 6;
    localparam int TEST_CYCLES = 200;   // Bound for one directed test

    logic     clk = 1'b0;
    logic     rst;
    logic     cache_on;
    logic     new_request;
    ls_req_t  ls_req;
    logic     ready;
    logic     data_valid;
    word_t    data_out;
    logic     mem_request;
    logic     mem_ack;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     inv_ack;
    int       word_errors;
    int       req_errors;
    int       other_errors;
    word_t    addr_a;                   // Line 5, cached by the first test

    always #(CLK_PERIOD / 2) clk = ~clk;

    dcache dut0 (.*);

    mem_model mem0 (
        .clk, .rst, .inv_ack,
        .request (mem_request),
        .req     (mem_req),
        .ack     (mem_ack),
        .rsp     (mem_rsp)
    );

    function automatic word_t make_addr(input int tag, input int idx, input int word);
        return word_t'((tag << (LINE_IDX_W + LINE_OFS_W)) | (idx << LINE_OFS_W) | (word << 2));
    endfunction

    // Fill request for the line holding addr
    function automatic mem_req_t line_req(input word_t addr);
        return '{addr: addr & ~word_t'(LINE_WORDS * 4 - 1), rnw: 1'b1, be: 4'hf,
                 data: 32'h0, size: 2'(LINE_WORDS - 1)};
    endfunction

    function automatic mem_req_t word_req(input word_t addr, input logic rnw,
                                          input be_t be, input word_t data);
        return '{addr: addr, rnw: rnw, be: be, data: data, size: 2'd0};
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data, input be_t be);
        word_t w;
        w = old;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = data[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
            word_errors++;
        end
    endtask

    task automatic check_mem_req(input string what, input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s, got %p, expected %p", $time, what, got, exp);
            req_errors++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("Error at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            other_errors++;
        end
    endtask

    // One-cycle new_request strobe, issued only while ready
    task automatic start_request(input ls_req_t r);
        while (!ready) @(negedge clk);
        @(posedge clk);
        #1;
        new_request = 1'b1;
        ls_req      = r;
        @(posedge clk);
        #1;
        new_request = 1'b0;
    endtask

    // A miss costs exactly one memory read, a hit none and 2 cycles
    task automatic load_and_check(input string what, input word_t addr, input bit miss);
        int latency;
        int reads;
        reads   = mem0.read_count;
        latency = 0;
        start_request('{addr: addr, load: 1'b1, store: 1'b0, be: 4'hf, data: 32'h0});
        do begin
            @(negedge clk);
            latency++;
        end while (!data_valid);
        check_word(what, data_out, mem0.read_word(addr));
        check_count({what, ", memory reads"}, mem0.read_count - reads, miss ? 1 : 0);
        if (!miss) begin
            check_count({what, ", hit latency"}, latency, 2);
        end
    endtask

    task automatic store_word(input word_t addr, input be_t be, input word_t data);
        start_request('{addr: addr, load: 1'b0, store: 1'b1, be: be, data: data});
        do begin
            @(negedge clk);
            if (data_valid) begin
                $display("A store raised data_valid at %0t", $time);
                other_errors++;
            end
        end while (!ready);
    endtask

    task automatic load_miss_fill();
        addr_a = make_addr(3, 5, 2);
        load_and_check("load miss", addr_a, 1'b1);
        check_mem_req("line fill request", mem0.last_req, line_req(addr_a));
    endtask

    task automatic repeat_load_hit();
        load_and_check("repeat load hit", make_addr(3, 5, 3), 1'b0);
    endtask

    task automatic store_hit_write_through();
        word_t data;
        word_t merged;
        int    writes;
        data   = $urandom;
        merged = merge_bytes(mem0.read_word(addr_a), data, 4'b0110);
        writes = mem0.write_count;
        store_word(addr_a, 4'b0110, data);
        check_count("store hit, memory writes", mem0.write_count - writes, 1);
        check_mem_req("store hit request", mem0.last_req, word_req(addr_a, 1'b0, 4'b0110, data));
        check_word("memory after store hit", mem0.read_word(addr_a), merged);
        load_and_check("load after store hit", addr_a, 1'b0);
    endtask

    task automatic store_miss_no_alloc();
        word_t addr_b;
        word_t data;
        addr_b = make_addr(7, 9, 1);
        data   = $urandom;
        store_word(addr_b, 4'hf, data);
        check_word("memory after store miss", mem0.read_word(addr_b), data);
        load_and_check("load after store miss", addr_b, 1'b1);
        check_mem_req("line request after store miss", mem0.last_req, line_req(addr_b));
    endtask

    // Three tags on line 12, the third fill lands on the first one's way
    task automatic replacement_round_robin();
        for (int t = 1; t <= 3; t++) begin
            load_and_check("replacement fill", make_addr(t, 12, t), 1'b1);
        end
        load_and_check("second tag kept", make_addr(2, 12, 0), 1'b0);
        load_and_check("first tag evicted", make_addr(1, 12, 0), 1'b1);
    endtask

    task automatic invalidate_and_uncached();
        int cycles;
        load_and_check("cached before invalidation", addr_a, 1'b0);
        mem0.invalidate(addr_a, cycles);
        check_count("inv_ack delay", cycles, 1);
        load_and_check("load after invalidation", addr_a, 1'b1);
        @(posedge clk);
        #1;
        cache_on = 1'b0;
        for (int n = 0; n < 2; n++) begin
            load_and_check("uncached load", addr_a, 1'b1);
            check_mem_req("uncached request", mem0.last_req,
                          word_req(addr_a, 1'b1, 4'hf, 32'h0));
        end
        @(posedge clk);
        #1;
        cache_on = 1'b1;
    endtask

    initial begin
        void'($urandom(32'hbf96_0a95));
        rst          = 1'b1;
        cache_on     = 1'b1;
        new_request  = 1'b0;
        ls_req       = '0;
        word_errors  = 0;
        req_errors   = 0;
        other_errors = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        load_miss_fill();
        repeat_load_hit();
        store_hit_write_through();
        store_miss_no_alloc();
        replacement_round_robin();
        invalidate_and_uncached();
        $display("Errors: data %0d, request %0d, other %0d",
                 word_errors, req_errors, other_errors);
        if (word_errors + req_errors + other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the tests did not end within %0d cycles",
                 N_TESTS * TEST_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* test/mem_model.sv */
`timescale 1ns/10ps

module mem_model
    import dbus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     request,
    input  mem_req_t req,
    input  logic     inv_ack,
    output logic     ack,
    output mem_rsp_t rsp
);

    typedef logic [11:0] widx_t;    // 4096 words cover byte addresses below 16 KiB

    word_t    mem [4096];
    logic     dv;
    word_t    dv_data;
    logic     inv_v = 1'b0;
    word_t    inv_a = '0;
    int       read_count;           // Read requests of a line or a single word
    int       write_count;
    mem_req_t last_req;

    assign rsp = '{data_valid: dv, data: dv_data, inv_valid: inv_v, inv_addr: inv_a,
                   inv_ack: 1'b0};

    function automatic word_t read_word(input word_t addr);
        return mem[addr[13:2]];
    endfunction

    // Ack two cycles after the request is seen, then stream read words
    task automatic serve(input mem_req_t r);
        widx_t base;
        base     = r.addr[13:2];
        last_req = r;
        repeat (2) @(posedge clk);
        #1;
        ack = 1'b1;
        if (r.rnw) begin
            read_count++;
        end else begin
            write_count++;
            for (int b = 0; b < BE_W; b++) begin
                if (r.be[b]) begin
                    mem[base][8*b +: 8] = r.data[8*b +: 8];
                end
            end
        end
        @(posedge clk);
        #1;
        ack = 1'b0;
        if (r.rnw) begin
            for (int i = 0; i <= int'(r.size); i++) begin
                dv      = 1'b1;
                dv_data = mem[base + widx_t'(i)];
                @(posedge clk);
                #1;
            end
            dv = 1'b0;
        end
    endtask

    // Whole cycles from raising inv_valid to seeing inv_ack
    task automatic invalidate(input word_t addr, output int cycles);
        @(posedge clk);
        #1;
        inv_v  = 1'b1;
        inv_a  = addr;
        cycles = 0;
        @(negedge clk);
        while (!inv_ack) begin
            cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        inv_v = 1'b0;
    endtask

    initial begin
        ack         = 1'b0;
        dv          = 1'b0;
        dv_data     = '0;
        read_count  = 0;
        write_count = 0;
        last_req    = '0;
        for (int i = 0; i < 4096; i++) begin
            mem[widx_t'(i)] = (word_t'(i) * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
        end
        forever begin
            @(negedge clk);
            if (!rst && request) begin
                serve(req);
            end
        end
    end

endmodule
